/* Bender.yml */
package:
  name: back_end

sources:
  - cpu_pkg.sv
  - alu.sv
  - ex_mem.sv
  - data_mem.sv
  - mem_wb.sv
  - wb_select.sv
  - mem_fwd_unit.sv
  - back_end_top.sv
  - target: simulation
    files:
      - tb_back_end.sv

/* alu.sv */
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
   input  logic [ALU_OP_W-1:0] alu_op,
   input  logic                alu_src,
   input  logic [DATA_W-1:0]   rd_data_1,
   input  logic [DATA_W-1:0]   rd_data_2,
   input  logic [DATA_W-1:0]   sext_imm,
   output logic [DATA_W-1:0]   alu_out,
   output logic                alu_ofl,
   output logic                alu_zero,
   output logic                alu_ltz,
   output logic                alu_lteq
);

   logic [DATA_W-1:0]   op_a;
   logic [DATA_W-1:0]   op_b;
   logic [SHAMT_W-1:0]  shamt;
   logic [DATA_W-1:0]   sum;
   logic [DATA_W-1:0]   diff;
   logic                add_ofl;
   logic                sub_ofl;
   logic [2*DATA_W-1:0] rol_full;
   logic [2*DATA_W-1:0] ror_full;

   assign op_a  = rd_data_1;
   assign op_b  = alu_src ? sext_imm : rd_data_2;
   assign shamt = op_b[SHAMT_W-1:0];

   assign sum  = op_a + op_b;
   assign diff = op_a - op_b;

   // Signed overflow from the operand and result sign bits.
   assign add_ofl = (op_a[DATA_W-1] == op_b[DATA_W-1]) &&
                    (sum[DATA_W-1] != op_a[DATA_W-1]);
   assign sub_ofl = (op_a[DATA_W-1] != op_b[DATA_W-1]) &&
                    (diff[DATA_W-1] != op_a[DATA_W-1]);

   // Doubled word so a rotate is a plain shift.
   assign rol_full = {op_a, op_a} << shamt;
   assign ror_full = {op_a, op_a} >> shamt;

   always_comb begin
      case (alu_op)
         ALU_ADD: alu_out = sum;
         ALU_SUB: alu_out = diff;
         ALU_AND: alu_out = op_a & op_b;
         ALU_XOR: alu_out = op_a ^ op_b;
         ALU_SLL: alu_out = op_a << shamt;
         ALU_SRL: alu_out = op_a >> shamt;
         ALU_ROL: alu_out = rol_full[2*DATA_W-1:DATA_W];
         default: alu_out = ror_full[DATA_W-1:0];
      endcase
   end

   always_comb begin
      case (alu_op)
         ALU_ADD: alu_ofl = add_ofl;
         ALU_SUB: alu_ofl = sub_ofl;
         default: alu_ofl = 1'b0;
      endcase
   end

   assign alu_zero = (alu_out == '0);
   assign alu_ltz  = diff[DATA_W-1] ^ sub_ofl;  // Sign of A-B, fixed on overflow.
   assign alu_lteq = alu_ltz | alu_zero;

endmodule

/* back_end_top.sv */
`timescale 1ns/1ps

module back_end_top import cpu_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 stall_n,
   input  logic [DATA_W-1:0]    in_pc_inc,
   input  logic [DATA_W-1:0]    in_rd_data_1,
   input  logic [DATA_W-1:0]    in_rd_data_2,
   input  logic [REG_W-1:0]     in_rd_reg_2,
   input  logic [DATA_W-1:0]    in_sext_imm,
   input  logic [ALU_OP_W-1:0]  in_alu_op,
   input  logic                 in_alu_src,
   input  logic [SET_SEL_W-1:0] in_set_sel,
   input  logic                 in_mem_wr,
   input  logic                 in_mem_en,
   input  logic                 in_wr_en,
   input  logic [REG_W-1:0]     in_wr_reg,
   input  logic [WB_SEL_W-1:0]  in_wr_sel,
   input  logic [DATA_W-1:0]    in_lbi,
   input  logic [DATA_W-1:0]    in_slbi,
   input  logic                 in_halt,
   output logic                 wb_en,
   output logic [REG_W-1:0]     wb_reg,
   output logic [DATA_W-1:0]    wb_data,
   output logic                 halt
);

   // Execute stage results.
   logic [DATA_W-1:0] ex_alu_out;
   logic ex_alu_ofl, ex_alu_zero, ex_alu_ltz, ex_alu_lteq;

   logic              mem_mem_fwd;
   logic [DATA_W-1:0] fwd_data;

   // EX/MEM contents.
   logic [DATA_W-1:0]    xm_pc_inc, xm_rd_data_2, xm_alu_out, xm_lbi, xm_slbi;
   logic                 xm_alu_ofl, xm_alu_zero, xm_alu_ltz, xm_alu_lteq;
   logic [SET_SEL_W-1:0] xm_set_sel;
   logic                 xm_mem_wr, xm_mem_en, xm_wr_en, xm_halt;
   logic [REG_W-1:0]     xm_wr_reg;
   logic [WB_SEL_W-1:0]  xm_wr_sel;
   logic [DATA_W-1:0]    mem_rd_data;

   // MEM/WB contents.
   logic [DATA_W-1:0]    mw_mem_data, mw_alu_out, mw_pc_inc, mw_lbi, mw_slbi;
   logic                 mw_alu_ofl, mw_alu_zero, mw_alu_ltz, mw_alu_lteq;
   logic [SET_SEL_W-1:0] mw_set_sel;
   logic                 mw_wr_en;
   logic [REG_W-1:0]     mw_wr_reg;
   logic [WB_SEL_W-1:0]  mw_wr_sel;

   alu u_alu (
      .alu_op(in_alu_op), .alu_src(in_alu_src), .rd_data_1(in_rd_data_1),
      .rd_data_2(in_rd_data_2), .sext_imm(in_sext_imm), .alu_out(ex_alu_out),
      .alu_ofl(ex_alu_ofl), .alu_zero(ex_alu_zero), .alu_ltz(ex_alu_ltz),
      .alu_lteq(ex_alu_lteq)
   );

   mem_fwd_unit u_mem_fwd_unit (
      .in_mem_wr(in_mem_wr), .in_rd_reg_2(in_rd_reg_2), .wb_en(wb_en),
      .wb_reg(wb_reg), .wb_data(wb_data), .mem_mem_fwd(mem_mem_fwd),
      .fwd_data(fwd_data)
   );

   ex_mem u_ex_mem (
      .clk(clk), .rst_n(rst_n), .stall_n(stall_n),
      .in_pc_inc(in_pc_inc), .in_rd_data_2(in_rd_data_2),
      .mem_mem_fwd(mem_mem_fwd), .fwd_data(fwd_data),
      .in_alu_out(ex_alu_out), .in_alu_ofl(ex_alu_ofl), .in_alu_zero(ex_alu_zero),
      .in_alu_ltz(ex_alu_ltz), .in_alu_lteq(ex_alu_lteq), .in_set_sel(in_set_sel),
      .in_mem_wr(in_mem_wr), .in_mem_en(in_mem_en), .in_wr_en(in_wr_en),
      .in_wr_reg(in_wr_reg), .in_wr_sel(in_wr_sel), .in_lbi(in_lbi),
      .in_slbi(in_slbi), .in_halt(in_halt),
      .out_pc_inc(xm_pc_inc), .out_rd_data_2(xm_rd_data_2),
      .out_alu_out(xm_alu_out), .out_alu_ofl(xm_alu_ofl),
      .out_alu_zero(xm_alu_zero), .out_alu_ltz(xm_alu_ltz),
      .out_alu_lteq(xm_alu_lteq), .out_set_sel(xm_set_sel),
      .out_mem_wr(xm_mem_wr), .out_mem_en(xm_mem_en), .out_wr_en(xm_wr_en),
      .out_wr_reg(xm_wr_reg), .out_wr_sel(xm_wr_sel), .out_lbi(xm_lbi),
      .out_slbi(xm_slbi), .out_halt(xm_halt)
   );

   data_mem u_data_mem (
      .clk(clk), .rst_n(rst_n), .stall_n(stall_n),
      .addr(xm_alu_out[ADDR_W-1:0]),  // Word address is the low byte.
      .wr_data(xm_rd_data_2), .mem_en(xm_mem_en), .mem_wr(xm_mem_wr),
      .rd_data(mem_rd_data)
   );

   mem_wb u_mem_wb (
      .clk(clk), .rst_n(rst_n), .stall_n(stall_n),
      .in_mem_data(mem_rd_data), .in_alu_out(xm_alu_out), .in_pc_inc(xm_pc_inc),
      .in_alu_ofl(xm_alu_ofl), .in_alu_zero(xm_alu_zero), .in_alu_ltz(xm_alu_ltz),
      .in_alu_lteq(xm_alu_lteq), .in_set_sel(xm_set_sel), .in_wr_en(xm_wr_en),
      .in_wr_reg(xm_wr_reg), .in_wr_sel(xm_wr_sel), .in_lbi(xm_lbi),
      .in_slbi(xm_slbi), .in_halt(xm_halt),
      .out_mem_data(mw_mem_data), .out_alu_out(mw_alu_out),
      .out_pc_inc(mw_pc_inc), .out_alu_ofl(mw_alu_ofl),
      .out_alu_zero(mw_alu_zero), .out_alu_ltz(mw_alu_ltz),
      .out_alu_lteq(mw_alu_lteq), .out_set_sel(mw_set_sel),
      .out_wr_en(mw_wr_en), .out_wr_reg(mw_wr_reg), .out_wr_sel(mw_wr_sel),
      .out_lbi(mw_lbi), .out_slbi(mw_slbi), .out_halt(halt)
   );

   wb_select u_wb_select (
      .wr_en(mw_wr_en), .wr_reg(mw_wr_reg), .wr_sel(mw_wr_sel),
      .alu_out(mw_alu_out), .mem_data(mw_mem_data), .pc_inc(mw_pc_inc),
      .lbi(mw_lbi), .slbi(mw_slbi), .alu_ofl(mw_alu_ofl),
      .alu_zero(mw_alu_zero), .alu_ltz(mw_alu_ltz), .alu_lteq(mw_alu_lteq),
      .set_sel(mw_set_sel), .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
   );

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

   // Machine word and register file geometry.
   localparam int DATA_W    = 16;
   localparam int REG_W     = 3;
   localparam int MEM_DEPTH = 256;
   localparam int ADDR_W    = $clog2(MEM_DEPTH);
   localparam int SHAMT_W   = $clog2(DATA_W);

   localparam int ALU_OP_W  = 3;
   localparam int SET_SEL_W = 2;
   localparam int WB_SEL_W  = 3;

   // ALU operations.
   localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
   localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;  // A minus B.
   localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
   localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd3;
   localparam logic [ALU_OP_W-1:0] ALU_SLL = 3'd4;
   localparam logic [ALU_OP_W-1:0] ALU_SRL = 3'd5;
   localparam logic [ALU_OP_W-1:0] ALU_ROL = 3'd6;
   localparam logic [ALU_OP_W-1:0] ALU_ROR = 3'd7;

   // Set-instruction conditions.
   localparam logic [SET_SEL_W-1:0] SET_EQ  = 2'd0;
   localparam logic [SET_SEL_W-1:0] SET_LT  = 2'd1;
   localparam logic [SET_SEL_W-1:0] SET_LE  = 2'd2;
   localparam logic [SET_SEL_W-1:0] SET_OFL = 2'd3;

   // Writeback sources.
   localparam logic [WB_SEL_W-1:0] WB_ALU  = 3'd0;
   localparam logic [WB_SEL_W-1:0] WB_MEM  = 3'd1;
   localparam logic [WB_SEL_W-1:0] WB_PC   = 3'd2;  // PC plus two.
   localparam logic [WB_SEL_W-1:0] WB_SET  = 3'd3;
   localparam logic [WB_SEL_W-1:0] WB_LBI  = 3'd4;
   localparam logic [WB_SEL_W-1:0] WB_SLBI = 3'd5;

endpackage

/* data_mem.sv */
`timescale 1ns/1ps

module data_mem import cpu_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              stall_n,
   input  logic [ADDR_W-1:0] addr,
   input  logic [DATA_W-1:0] wr_data,
   input  logic              mem_en,
   input  logic              mem_wr,
   output logic [DATA_W-1:0] rd_data
);

   logic [DATA_W-1:0] mem [MEM_DEPTH];
   logic              wr_fire;

   // No write while the pipeline is frozen.
   assign wr_fire = mem_en & mem_wr & stall_n;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_fire) begin
         mem[addr] <= wr_data;
      end
   end

   // Read is combinational and returns zero when the memory is not enabled.
   assign rd_data = mem_en ? mem[addr] : '0;

endmodule

/* ex_mem.sv */
`timescale 1ns/1ps

module ex_mem import cpu_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 stall_n,
   input  logic [DATA_W-1:0]    in_pc_inc,
   input  logic [DATA_W-1:0]    in_rd_data_2,
   input  logic                 mem_mem_fwd,
   input  logic [DATA_W-1:0]    fwd_data,
   input  logic [DATA_W-1:0]    in_alu_out,
   input  logic                 in_alu_ofl,
   input  logic                 in_alu_zero,
   input  logic                 in_alu_ltz,
   input  logic                 in_alu_lteq,
   input  logic [SET_SEL_W-1:0] in_set_sel,
   input  logic                 in_mem_wr,
   input  logic                 in_mem_en,
   input  logic                 in_wr_en,
   input  logic [REG_W-1:0]     in_wr_reg,
   input  logic [WB_SEL_W-1:0]  in_wr_sel,
   input  logic [DATA_W-1:0]    in_lbi,
   input  logic [DATA_W-1:0]    in_slbi,
   input  logic                 in_halt,
   output logic [DATA_W-1:0]    out_pc_inc,
   output logic [DATA_W-1:0]    out_rd_data_2,
   output logic [DATA_W-1:0]    out_alu_out,
   output logic                 out_alu_ofl,
   output logic                 out_alu_zero,
   output logic                 out_alu_ltz,
   output logic                 out_alu_lteq,
   output logic [SET_SEL_W-1:0] out_set_sel,
   output logic                 out_mem_wr,
   output logic                 out_mem_en,
   output logic                 out_wr_en,
   output logic [REG_W-1:0]     out_wr_reg,
   output logic [WB_SEL_W-1:0]  out_wr_sel,
   output logic [DATA_W-1:0]    out_lbi,
   output logic [DATA_W-1:0]    out_slbi,
   output logic                 out_halt
);

   logic [DATA_W-1:0] store_data;

   // Take the value being written back when the store reads a stale register.
   assign store_data = mem_mem_fwd ? fwd_data : in_rd_data_2;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_pc_inc    <= '0;
         out_rd_data_2 <= '0;
         out_alu_out   <= '0;
         out_alu_ofl   <= 1'b0;
         out_alu_zero  <= 1'b0;
         out_alu_ltz   <= 1'b0;
         out_alu_lteq  <= 1'b0;
         out_set_sel   <= '0;
         out_mem_wr    <= 1'b0;
         out_mem_en    <= 1'b0;
         out_wr_en     <= 1'b0;
         out_wr_reg    <= '0;
         out_wr_sel    <= '0;
         out_lbi       <= '0;
         out_slbi      <= '0;
         out_halt      <= 1'b0;
      end else if (stall_n) begin  // Hold everything while stalled.
         out_pc_inc    <= in_pc_inc;
         out_rd_data_2 <= store_data;
         out_alu_out   <= in_alu_out;
         out_alu_ofl   <= in_alu_ofl;
         out_alu_zero  <= in_alu_zero;
         out_alu_ltz   <= in_alu_ltz;
         out_alu_lteq  <= in_alu_lteq;
         out_set_sel   <= in_set_sel;
         out_mem_wr    <= in_mem_wr;
         out_mem_en    <= in_mem_en;
         out_wr_en     <= in_wr_en;
         out_wr_reg    <= in_wr_reg;
         out_wr_sel    <= in_wr_sel;
         out_lbi       <= in_lbi;
         out_slbi      <= in_slbi;
         out_halt      <= in_halt;
      end
   end

endmodule

/* mem_fwd_unit.sv */
`timescale 1ns/1ps

module mem_fwd_unit import cpu_pkg::*; (
   input  logic              in_mem_wr,
   input  logic [REG_W-1:0]  in_rd_reg_2,
   input  logic              wb_en,
   input  logic [REG_W-1:0]  wb_reg,
   input  logic [DATA_W-1:0] wb_data,
   output logic              mem_mem_fwd,
   output logic [DATA_W-1:0] fwd_data
);

   logic reg_match;

   // The store's data register is the one being written back this cycle.
   assign reg_match = (in_rd_reg_2 == wb_reg);

   assign mem_mem_fwd = in_mem_wr & wb_en & reg_match;
   assign fwd_data    = wb_data;

endmodule

/* mem_wb.sv */
`timescale 1ns/1ps

module mem_wb import cpu_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 stall_n,
   input  logic [DATA_W-1:0]    in_mem_data,
   input  logic [DATA_W-1:0]    in_alu_out,
   input  logic [DATA_W-1:0]    in_pc_inc,
   input  logic                 in_alu_ofl,
   input  logic                 in_alu_zero,
   input  logic                 in_alu_ltz,
   input  logic                 in_alu_lteq,
   input  logic [SET_SEL_W-1:0] in_set_sel,
   input  logic                 in_wr_en,
   input  logic [REG_W-1:0]     in_wr_reg,
   input  logic [WB_SEL_W-1:0]  in_wr_sel,
   input  logic [DATA_W-1:0]    in_lbi,
   input  logic [DATA_W-1:0]    in_slbi,
   input  logic                 in_halt,
   output logic [DATA_W-1:0]    out_mem_data,
   output logic [DATA_W-1:0]    out_alu_out,
   output logic [DATA_W-1:0]    out_pc_inc,
   output logic                 out_alu_ofl,
   output logic                 out_alu_zero,
   output logic                 out_alu_ltz,
   output logic                 out_alu_lteq,
   output logic [SET_SEL_W-1:0] out_set_sel,
   output logic                 out_wr_en,
   output logic [REG_W-1:0]     out_wr_reg,
   output logic [WB_SEL_W-1:0]  out_wr_sel,
   output logic [DATA_W-1:0]    out_lbi,
   output logic [DATA_W-1:0]    out_slbi,
   output logic                 out_halt
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_mem_data <= '0;
         out_alu_out  <= '0;
         out_pc_inc   <= '0;
         out_alu_ofl  <= 1'b0;
         out_alu_zero <= 1'b0;
         out_alu_ltz  <= 1'b0;
         out_alu_lteq <= 1'b0;
         out_set_sel  <= '0;
         out_wr_en    <= 1'b0;
         out_wr_reg   <= '0;
         out_wr_sel   <= '0;
         out_lbi      <= '0;
         out_slbi     <= '0;
         out_halt     <= 1'b0;
      end else if (stall_n) begin
         out_mem_data <= in_mem_data;
         out_alu_out  <= in_alu_out;
         out_pc_inc   <= in_pc_inc;
         out_alu_ofl  <= in_alu_ofl;
         out_alu_zero <= in_alu_zero;
         out_alu_ltz  <= in_alu_ltz;
         out_alu_lteq <= in_alu_lteq;
         out_set_sel  <= in_set_sel;
         out_wr_en    <= in_wr_en;
         out_wr_reg   <= in_wr_reg;
         out_wr_sel   <= in_wr_sel;
         out_lbi      <= in_lbi;
         out_slbi     <= in_slbi;
         out_halt     <= in_halt;
      end
   end

endmodule

/* tb_back_end.sv */
`timescale 1ns/1ps

module tb_back_end import cpu_pkg::*; ();

   typedef struct packed {
      logic [DATA_W-1:0]    pc_inc;
      logic [DATA_W-1:0]    rd_data_1;
      logic [DATA_W-1:0]    rd_data_2;
      logic [REG_W-1:0]     rd_reg_2;
      logic [DATA_W-1:0]    sext_imm;
      logic [ALU_OP_W-1:0]  alu_op;
      logic                 alu_src;
      logic [SET_SEL_W-1:0] set_sel;
      logic                 mem_wr;
      logic                 mem_en;
      logic                 wr_en;
      logic [REG_W-1:0]     wr_reg;
      logic [WB_SEL_W-1:0]  wr_sel;
      logic [DATA_W-1:0]    lbi;
      logic [DATA_W-1:0]    slbi;
      logic                 halt;
   } instr_t;

   typedef struct packed {
      logic              wb_en;
      logic [REG_W-1:0]  wb_reg;
      logic [DATA_W-1:0] wb_data;
      logic              halt;
   } expect_t;

   logic              clk = 1'b0;
   logic              rst_n;
   logic              stall_n;
   instr_t            cmd;
   logic              wb_en;
   logic [REG_W-1:0]  wb_reg;
   logic [DATA_W-1:0] wb_data;
   logic              halt;

   logic [31:0]       rng_state = 32'h4d99;
   logic [DATA_W-1:0] model_mem [MEM_DEPTH];
   expect_t           hist_1 = '0;  // Last two modelled writebacks.
   expect_t           hist_2 = '0;
   expect_t           exp_q [$];
   expect_t           cur = '0;

   back_end_top DUT (
      .clk(clk), .rst_n(rst_n), .stall_n(stall_n),
      .in_pc_inc(cmd.pc_inc), .in_rd_data_1(cmd.rd_data_1), .in_rd_data_2(cmd.rd_data_2),
      .in_rd_reg_2(cmd.rd_reg_2), .in_sext_imm(cmd.sext_imm), .in_alu_op(cmd.alu_op),
      .in_alu_src(cmd.alu_src), .in_set_sel(cmd.set_sel), .in_mem_wr(cmd.mem_wr),
      .in_mem_en(cmd.mem_en), .in_wr_en(cmd.wr_en), .in_wr_reg(cmd.wr_reg),
      .in_wr_sel(cmd.wr_sel), .in_lbi(cmd.lbi), .in_slbi(cmd.slbi), .in_halt(cmd.halt),
      .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data), .halt(halt)
   );

   always #5 clk = ~clk;

   function automatic logic [15:0] rand16();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state[31:16];
   endfunction

   function automatic instr_t random_instr();
      instr_t      t;
      logic [15:0] r;
      t.pc_inc    = rand16();
      t.rd_data_1 = rand16();
      t.rd_data_2 = rand16();
      t.sext_imm  = rand16();
      t.lbi       = rand16();
      t.slbi      = rand16();
      r           = rand16();
      t.alu_op    = r[2:0];
      t.alu_src   = r[3];
      t.set_sel   = r[5:4];
      t.rd_reg_2  = r[8:6];
      t.wr_reg    = r[11:9];
      t.wr_en     = r[12] | r[13];
      t.mem_en    = (r[15:14] == 2'd0);
      r           = rand16();
      t.mem_wr    = r[0];
      t.wr_sel    = r[3:1] % 6;
      t.halt      = 1'b0;
      if (r[6:4] == 3'd0) begin  // Equal operands reach the zero cases.
         t.rd_data_2 = t.rd_data_1;
         t.alu_src   = 1'b0;
      end
      // Memory traffic stays in a small window so loads find earlier stores.
      if (t.mem_en) begin
         t.alu_op    = ALU_ADD;
         t.alu_src   = 1'b1;
         t.rd_data_1 = {12'd0, r[10:7]};
         t.sext_imm  = 16'h0080;
      end
      return t;
   endfunction

   function automatic instr_t mem_access(logic [DATA_W-1:0] addr, logic [DATA_W-1:0] data,
                                         logic [REG_W-1:0] reg2, logic en, logic wr);
      instr_t t;
      t           = '0;
      t.alu_op    = ALU_ADD;
      t.alu_src   = 1'b1;
      t.rd_data_1 = addr;
      t.rd_data_2 = data;
      t.rd_reg_2  = reg2;
      t.mem_en    = en;
      t.mem_wr    = wr;
      t.wr_en     = !wr;
      t.wr_reg    = 3'd3;
      t.wr_sel    = WB_MEM;
      return t;
   endfunction

   // Expected writeback of one instruction. Its store also lands in model_mem.
   function automatic expect_t model_instr(instr_t t);
      expect_t           e;
      logic [DATA_W-1:0] b;
      logic [DATA_W-1:0] res;
      logic [DATA_W-1:0] st_data;
      logic [DATA_W-1:0] rd;
      logic [ADDR_W-1:0] addr;
      logic              ofl;
      logic              set_bit;
      int                sa;
      int                sb;
      int                sr;
      int                s;
      b   = t.alu_src ? t.sext_imm : t.rd_data_2;
      sa  = $signed(t.rd_data_1);
      sb  = $signed(b);
      s   = b[3:0];
      ofl = 1'b0;
      case (t.alu_op)
         ALU_ADD: begin
            sr  = sa + sb;
            res = sr[15:0];
            ofl = (sr > 32767) || (sr < -32768);
         end
         ALU_SUB: begin
            sr  = sa - sb;
            res = sr[15:0];
            ofl = (sr > 32767) || (sr < -32768);
         end
         ALU_AND: res = t.rd_data_1 & b;
         ALU_XOR: res = t.rd_data_1 ^ b;
         ALU_SLL: res = t.rd_data_1 << s;
         ALU_SRL: res = t.rd_data_1 >> s;
         ALU_ROL: res = (t.rd_data_1 << s) | (t.rd_data_1 >> (16 - s));
         default: res = (t.rd_data_1 >> s) | (t.rd_data_1 << (16 - s));
      endcase
      case (t.set_sel)
         SET_EQ:  set_bit = (res == 0);
         SET_LT:  set_bit = (sa < sb);
         SET_LE:  set_bit = (sa < sb) || (res == 0);
         default: set_bit = ofl;
      endcase
      // The instruction two slots ahead is the one in writeback at capture time.
      addr    = res[ADDR_W-1:0];
      st_data = (t.mem_wr && hist_2.wb_en && hist_2.wb_reg == t.rd_reg_2) ?
                hist_2.wb_data : t.rd_data_2;
      rd      = t.mem_en ? model_mem[addr] : '0;
      if (t.mem_en && t.mem_wr) begin
         model_mem[addr] = st_data;
      end
      e.wb_en  = t.wr_en;
      e.wb_reg = t.wr_reg;
      e.halt   = t.halt;
      case (t.wr_sel)
         WB_ALU:  e.wb_data = res;
         WB_MEM:  e.wb_data = rd;
         WB_PC:   e.wb_data = t.pc_inc;
         WB_SET:  e.wb_data = {15'd0, set_bit};
         WB_LBI:  e.wb_data = t.lbi;
         WB_SLBI: e.wb_data = t.slbi;
         default: e.wb_data = '0;
      endcase
      hist_2 = hist_1;
      hist_1 = e;
      return e;
   endfunction

   task automatic abort_run(string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic report_mismatch(string name, logic [DATA_W-1:0] got,
                                  logic [DATA_W-1:0] want);
      abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, want));
   endtask

   task automatic issue(instr_t t);
      stall_n = 1'b1;
      cmd     = t;
      exp_q.push_back(model_instr(t));
      @(posedge clk);
      #1;
   endtask

   task automatic stall_cycle();
      stall_n = 1'b0;
      cmd     = random_instr();  // Discarded by the DUT.
      @(posedge clk);
      #1;
   endtask

   // Each active edge moves the queue head onto the outputs.
   always @(posedge clk) begin
      if (rst_n && stall_n) begin
         cur = exp_q.pop_front();
      end
   end

   always @(negedge clk) begin
      assert (wb_en === cur.wb_en) else report_mismatch("wb_en", wb_en, cur.wb_en);
      assert (wb_reg === cur.wb_reg) else report_mismatch("wb_reg", wb_reg, cur.wb_reg);
      assert (wb_data === cur.wb_data) else report_mismatch("wb_data", wb_data, cur.wb_data);
      assert (halt === cur.halt) else report_mismatch("halt", halt, cur.halt);
   end

   initial begin
      instr_t      t;
      logic [15:0] r;
      int          cycles;
      rst_n   = 1'b0;
      stall_n = 1'b1;
      cmd     = '0;
      for (int i = 0; i < MEM_DEPTH; i++) begin
         model_mem[i] = '0;
      end
      exp_q.push_back('0);  // Reset contents of EX/MEM.
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Store and load back, then a load with the memory disabled.
      issue(mem_access(16'h0040, 16'h1234, 3'd0, 1'b1, 1'b1));
      issue(mem_access(16'h0040, 16'h0000, 3'd0, 1'b1, 1'b0));
      issue(mem_access(16'h0040, 16'h0000, 3'd0, 1'b0, 1'b0));

      t        = '0;
      t.wr_en  = 1'b1;
      t.wr_reg = 3'd6;
      t.wr_sel = WB_LBI;
      t.lbi    = 16'hbeef;
      issue(t);
      t.wr_reg = 3'd2;
      t.wr_sel = WB_PC;
      t.pc_inc = 16'h0102;
      issue(t);
      // r6 is in writeback now, so the stale 0bad must not be stored.
      issue(mem_access(16'h0041, 16'h0bad, 3'd6, 1'b1, 1'b1));
      issue(mem_access(16'h0041, 16'h0000, 3'd0, 1'b1, 1'b0));
      t.wr_sel = WB_SLBI;
      t.slbi   = 16'h5a5a;
      issue(t);

      for (int i = 0; i < 400; i++) begin
         r = rand16();
         if (r[2:0] == 3'd0) begin
            repeat (r[4:3] + 1) stall_cycle();
         end
         issue(random_instr());
      end

      t      = '0;
      t.halt = 1'b1;
      issue(t);
      cycles = 0;
      while (halt !== 1'b1) begin
         if (cycles > 40) begin
            abort_run("Timed out waiting for halt at the outputs.");
         end
         r = rand16();
         if (r[1:0] == 2'd0) begin
            stall_cycle();
         end else begin
            issue('0);
         end
         cycles++;
      end

      @(negedge clk);
      #1;
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

/* vlog.f */
cpu_pkg.sv
alu.sv
ex_mem.sv
data_mem.sv
mem_wb.sv
wb_select.sv
mem_fwd_unit.sv
back_end_top.sv
tb_back_end.sv

/* wb_select.sv */
`timescale 1ns/1ps

module wb_select import cpu_pkg::*; (
   input  logic                 wr_en,
   input  logic [REG_W-1:0]     wr_reg,
   input  logic [WB_SEL_W-1:0]  wr_sel,
   input  logic [DATA_W-1:0]    alu_out,
   input  logic [DATA_W-1:0]    mem_data,
   input  logic [DATA_W-1:0]    pc_inc,
   input  logic [DATA_W-1:0]    lbi,
   input  logic [DATA_W-1:0]    slbi,
   input  logic                 alu_ofl,
   input  logic                 alu_zero,
   input  logic                 alu_ltz,
   input  logic                 alu_lteq,
   input  logic [SET_SEL_W-1:0] set_sel,
   output logic                 wb_en,
   output logic [REG_W-1:0]     wb_reg,
   output logic [DATA_W-1:0]    wb_data
);

   logic set_bit;

   // Condition for the set instructions.
   always_comb begin
      case (set_sel)
         SET_EQ:  set_bit = alu_zero;
         SET_LT:  set_bit = alu_ltz;
         SET_LE:  set_bit = alu_lteq;
         default: set_bit = alu_ofl;
      endcase
   end

   always_comb begin
      case (wr_sel)
         WB_ALU:  wb_data = alu_out;
         WB_MEM:  wb_data = mem_data;
         WB_PC:   wb_data = pc_inc;
         WB_SET:  wb_data = {{(DATA_W-1){1'b0}}, set_bit};  // Zero extended.
         WB_LBI:  wb_data = lbi;
         WB_SLBI: wb_data = slbi;
         default: wb_data = '0;
      endcase
   end

   assign wb_en  = wr_en;
   assign wb_reg = wr_reg;

endmodule
